//--- compile.f
source/lsb_pkg.sv
source/lsb_queue.sv
source/lsb_cache.sv
source/load_extend.sv
source/lsb_top.sv
test/wb_mem_model.sv
test/tb_lsb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_lsb -o tb_lsb_sim

out=$(./obj_dir/tb_lsb_sim 2>&1) || true
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- test/tb_lsb.sv
`timescale 1ns/1ps

module tb_lsb;
  import lsb_pkg::*;

  localparam int unsigned SEED          = 89283;
  localparam int unsigned ISSUE_TIMEOUT = 2000;
  localparam int unsigned DRAIN_TIMEOUT = 3000;

  typedef enum logic [2:0] {K_ISSUE, K_CDB, K_COMMIT, K_QUIET, K_DRAIN, K_FULL} kind_e;

  typedef struct packed {
    kind_e       kind;
    mem_op_e     op;
    rob_tag_t    dest;
    rob_tag_t    qj;
    word_t       vj;
    word_t       vk;
    word_t       imm;
    rob_tag_t    cdb_tag;
    word_t       cdb_value;
    word_t       exp_value;
    logic [15:0] cycles;
  } step_t;

  typedef struct packed {
    rob_tag_t tag;
    word_t    value;
  } exp_t;

  logic         clk = 1'b0;
  logic         rst;
  issue_t       issue;
  cdb_t         cdb;
  rob_tag_t     commit_tag;
  logic         full;
  load_result_t load_result;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  word_t        wb_adr;
  line_t        wb_dat_w;
  line_t        wb_dat_r;
  logic         wb_ack;

  step_t        steps[$];
  exp_t         expected[$];
  exp_t         popped;
  logic [7:0]   ref_mem [1024];
  int unsigned  writebacks = 0;

  lsb_top lsb_top_i (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .full        (full),
    .cdb         (cdb),
    .commit_tag  (commit_tag),
    .load_result (load_result),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack)
  );

  wb_mem_model wb_mem_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #50 clk = ~clk;

  task automatic report_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_msg(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    report_failure();
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  function automatic line_t ref_line(input word_t addr);
    line_t l;
    for (int b = 0; b < LINE_BYTES; b++) begin
      l[b*8 +: 8] = ref_mem[{addr[9:4], 4'b0000} + b];
    end
    return l;
  endfunction

  task automatic store_ref(input mem_op_e op, input word_t addr, input word_t data);
    int n;
    n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    for (int b = 0; b < n; b++) begin
      ref_mem[int'(addr[9:0]) + b] = data[b*8 +: 8];
    end
  endtask

  task automatic add_issue(input mem_op_e op, input rob_tag_t dest, input rob_tag_t qj,
                           input word_t vj, input word_t vk, input word_t imm,
                           input rob_tag_t cdb_tag, input word_t exp_value);
    steps.push_back({K_ISSUE, op, dest, qj, vj, vk, imm, cdb_tag, 32'h100, exp_value, 16'd0});
  endtask

  task automatic add_ctl(input kind_e kind, input rob_tag_t tag, input word_t value,
                         input logic [15:0] cycles);
    steps.push_back({kind, OP_LW, 4'd0, 4'd0, 32'd0, 32'd0, 32'd0, tag, value, 32'd0, cycles});
  endtask

  task automatic do_issue(input step_t st);
    int unsigned waited;
    waited = 0;
    while (full) begin
      @(negedge clk);
      waited++;
      if (waited > ISSUE_TIMEOUT) fail_msg("queue stayed full, issue timed out");
    end
    issue = '{valid: 1'b1, op: st.op, dest: st.dest, qj: st.qj, qk: 4'd0,
              vj: st.vj, vk: st.vk, imm: st.imm};
    if (st.cdb_tag != '0) begin
      cdb = '{valid: 1'b1, tag: st.cdb_tag, value: st.cdb_value};
    end
    if (st.op inside {OP_SB, OP_SH, OP_SW}) begin
      store_ref(st.op, st.vj + st.imm, st.vk);
    end else begin
      expected.push_back('{tag: st.dest, value: st.exp_value});
    end
    @(negedge clk);
    issue = '0;
    cdb   = '0;
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (expected.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) fail_msg("timed out waiting for outstanding loads");
    end
    @(negedge clk);
  endtask

  task automatic expect_quiet(input int unsigned n);
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      if (load_result.valid) fail_msg("load result came out while the load was blocked");
    end
  endtask

  // results and victim write-backs checked as they appear
  always @(negedge clk) begin
    if (!rst && load_result.valid) begin
      if (expected.size() == 0) begin
        fail_msg("load result with no load outstanding");
      end else begin
        popped = expected.pop_front();
        check_tag("load_result.tag", load_result.tag, popped.tag);
        check_word("load_result.value", load_result.value, popped.value);
      end
    end
    if (!rst && wb_cyc && wb_stb && wb_we && wb_ack) begin
      check_line("wb_dat_w", wb_dat_w, ref_line(wb_adr));
      writebacks++;
    end
  end

  initial begin
    void'($urandom(SEED));
    rst        = 1'b1;
    issue      = '0;
    cdb        = '0;
    commit_tag = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < 64; i++) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        ref_mem[i*LINE_BYTES + b] = wb_mem_i.mem[i][b*8 +: 8];
      end
    end
    check_flag("full", full, 1'b0);
    check_flag("load_result.valid", load_result.valid, 1'b0);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);

    // every width and signedness after stores
    add_issue(OP_SW, 4'd1, 4'd0, 32'h100, 32'h8A7BF0C5, 32'h20, 4'd0, 32'h0);
    add_ctl(K_COMMIT, 4'd1, 32'h0, 16'd0);
    add_issue(OP_SB, 4'd2, 4'd0, 32'h100, 32'h0000007F, 32'h24, 4'd0, 32'h0);
    add_ctl(K_COMMIT, 4'd2, 32'h0, 16'd0);
    add_issue(OP_SB, 4'd3, 4'd0, 32'h100, 32'h00000080, 32'h25, 4'd0, 32'h0);
    add_ctl(K_COMMIT, 4'd3, 32'h0, 16'd0);
    add_issue(OP_SH, 4'd4, 4'd0, 32'h100, 32'h00009001, 32'h26, 4'd0, 32'h0);
    add_ctl(K_COMMIT, 4'd4, 32'h0, 16'd0);
    add_issue(OP_LW, 4'd5, 4'd0, 32'h100, 32'h0, 32'h20, 4'd0, 32'h8A7BF0C5);
    add_issue(OP_LB, 4'd6, 4'd0, 32'h100, 32'h0, 32'h20, 4'd0, 32'hFFFFFFC5);
    add_issue(OP_LBU, 4'd7, 4'd0, 32'h100, 32'h0, 32'h21, 4'd0, 32'h000000F0);
    add_issue(OP_LH, 4'd8, 4'd0, 32'h100, 32'h0, 32'h22, 4'd0, 32'hFFFF8A7B);
    add_issue(OP_LHU, 4'd9, 4'd0, 32'h100, 32'h0, 32'h20, 4'd0, 32'h0000F0C5);
    add_issue(OP_LB, 4'd10, 4'd0, 32'h100, 32'h0, 32'h23, 4'd0, 32'hFFFFFF8A);
    add_issue(OP_LBU, 4'd11, 4'd0, 32'h100, 32'h0, 32'h22, 4'd0, 32'h0000007B);
    add_issue(OP_LW, 4'd12, 4'd0, 32'h100, 32'h0, 32'h24, 4'd0, 32'h9001807F);
    add_issue(OP_LH, 4'd13, 4'd0, 32'h100, 32'h0, 32'h24, 4'd0, 32'hFFFF807F);
    add_issue(OP_LB, 4'd14, 4'd0, 32'h100, 32'h0, 32'h25, 4'd0, 32'hFFFFFF80);
    add_ctl(K_DRAIN, 4'd0, 32'h0, 16'd0);
    // base from the cdb later or in the issue cycle
    add_issue(OP_LW, 4'd1, 4'd6, 32'h0, 32'h0, 32'h24, 4'd0, 32'h9001807F);
    add_ctl(K_QUIET, 4'd0, 32'h0, 16'd20);
    add_ctl(K_CDB, 4'd6, 32'h100, 16'd0);
    add_ctl(K_DRAIN, 4'd0, 32'h0, 16'd0);
    add_issue(OP_LBU, 4'd2, 4'd8, 32'h0, 32'h0, 32'h23, 4'd8, 32'h0000008A);
    add_ctl(K_DRAIN, 4'd0, 32'h0, 16'd0);
    // load held behind an uncommitted store
    add_issue(OP_SW, 4'd3, 4'd0, 32'h100, 32'hCAFEF00D, 32'h28, 4'd0, 32'h0);
    add_issue(OP_LW, 4'd4, 4'd0, 32'h100, 32'h0, 32'h28, 4'd0, 32'hCAFEF00D);
    add_ctl(K_QUIET, 4'd0, 32'h0, 16'd40);
    add_ctl(K_COMMIT, 4'd3, 32'h0, 16'd0);
    add_ctl(K_DRAIN, 4'd0, 32'h0, 16'd0);
    // same index and another tag so dirty lines get evicted
    add_issue(OP_SW, 4'd5, 4'd0, 32'h100, 32'h0BADBEEF, 32'hA4, 4'd0, 32'h0);
    add_ctl(K_COMMIT, 4'd5, 32'h0, 16'd0);
    add_issue(OP_LW, 4'd6, 4'd0, 32'h100, 32'h0, 32'h28, 4'd0, 32'hCAFEF00D);
    add_issue(OP_LW, 4'd7, 4'd0, 32'h100, 32'h0, 32'hA4, 4'd0, 32'h0BADBEEF);
    add_ctl(K_DRAIN, 4'd0, 32'h0, 16'd0);
    // fill the queue with blocked loads
    add_issue(OP_LW, 4'd1, 4'd14, 32'h0, 32'h0, 32'h20, 4'd0, 32'h8A7BF0C5);
    add_issue(OP_LBU, 4'd2, 4'd14, 32'h0, 32'h0, 32'h21, 4'd0, 32'h000000F0);
    add_issue(OP_LB, 4'd3, 4'd14, 32'h0, 32'h0, 32'h23, 4'd0, 32'hFFFFFF8A);
    add_issue(OP_LHU, 4'd4, 4'd14, 32'h0, 32'h0, 32'h26, 4'd0, 32'h00009001);
    add_issue(OP_LH, 4'd5, 4'd14, 32'h0, 32'h0, 32'h24, 4'd0, 32'hFFFF807F);
    add_issue(OP_LW, 4'd6, 4'd14, 32'h0, 32'h0, 32'h28, 4'd0, 32'hCAFEF00D);
    add_issue(OP_LB, 4'd7, 4'd14, 32'h0, 32'h0, 32'h2A, 4'd0, 32'hFFFFFFFE);
    add_issue(OP_LBU, 4'd8, 4'd14, 32'h0, 32'h0, 32'hA4, 4'd0, 32'h000000EF);
    add_ctl(K_FULL, 4'd0, 32'h0, 16'd0);
    add_ctl(K_CDB, 4'd14, 32'h100, 16'd0);
    add_ctl(K_DRAIN, 4'd0, 32'h0, 16'd0);

    foreach (steps[s]) begin
      case (steps[s].kind)
        K_ISSUE: do_issue(steps[s]);
        K_CDB: begin
          cdb = '{valid: 1'b1, tag: steps[s].cdb_tag, value: steps[s].cdb_value};
          @(negedge clk);
          cdb = '0;
        end
        K_COMMIT: begin
          commit_tag = steps[s].cdb_tag;
          @(negedge clk);
          commit_tag = '0;
        end
        K_QUIET: expect_quiet(int'(steps[s].cycles));
        K_DRAIN: wait_drain();
        default: check_flag("full", full, 1'b1);
      endcase
    end

    if (writebacks < 2) begin
      fail_msg("fewer dirty line write-backs than expected");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- test/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
  input  logic                clk,
  input  logic                rst,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  lsb_pkg::word_t      wb_adr,
  input  lsb_pkg::line_t      wb_dat_w,
  output lsb_pkg::line_t      wb_dat_r,
  output logic                wb_ack
);
  import lsb_pkg::*;

  localparam int MEM_LINES = 64;

  line_t      mem [MEM_LINES];
  logic       filled = 1'b0;
  logic       busy;
  logic [1:0] delay;
  logic [5:0] line_idx;

  assign line_idx = wb_adr[9:4];

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      busy     <= 1'b0;
      delay    <= '0;
      // random contents drawn once during reset
      if (!filled) begin
        for (int i = 0; i < MEM_LINES; i++) begin
          mem[i] <= {$urandom(), $urandom(), $urandom(), $urandom()};
        end
        filled <= 1'b1;
      end
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy  <= 1'b1;
        delay <= 2'($urandom_range(3, 0));
      end else if (delay == '0) begin
        busy   <= 1'b0;
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[line_idx] <= wb_dat_w;
        end else begin
          wb_dat_r <= mem[line_idx];
        end
      end else begin
        delay <= delay - 1'b1;
      end
    end
  end

endmodule

//--- source/lsb_top.sv
`timescale 1ns/1ps

module lsb_top (
  input  logic                  clk,
  input  logic                  rst,
  input  lsb_pkg::issue_t       issue,
  output logic                  full,
  input  lsb_pkg::cdb_t         cdb,
  input  lsb_pkg::rob_tag_t     commit_tag,
  output lsb_pkg::load_result_t load_result,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output lsb_pkg::word_t        wb_adr,
  output lsb_pkg::line_t        wb_dat_w,
  input  lsb_pkg::line_t        wb_dat_r,
  input  logic                  wb_ack
);
  import lsb_pkg::*;

  head_req_t   head;
  logic        retire;
  mem_access_t load_access;

  lsb_queue lsb_queue_i (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .cdb        (cdb),
    .commit_tag (commit_tag),
    .retire     (retire),
    .head       (head),
    .full       (full)
  );

  lsb_cache lsb_cache_i (
    .clk         (clk),
    .rst         (rst),
    .head        (head),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .retire      (retire),
    .load_access (load_access),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w)
  );

  load_extend load_extend_i (
    .clk         (clk),
    .rst         (rst),
    .load_access (load_access),
    .load_result (load_result)
  );

endmodule

//--- source/load_extend.sv
`timescale 1ns/1ps

module load_extend (
  input  logic                  clk,
  input  logic                  rst,
  input  lsb_pkg::mem_access_t  load_access,
  output lsb_pkg::load_result_t load_result
);
  import lsb_pkg::*;

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  word_t       extended;

  // low offset bits pick the byte or half inside the lane
  assign lane_byte = load_access.word[{load_access.offset[1:0], 3'b000} +: 8];
  assign lane_half = load_access.word[{load_access.offset[1], 4'b0000} +: 16];

  always_comb begin
    case (load_access.op)
      OP_LB:   extended = {{24{lane_byte[7]}}, lane_byte};
      OP_LH:   extended = {{16{lane_half[15]}}, lane_half};
      OP_LBU:  extended = {24'b0, lane_byte};
      OP_LHU:  extended = {16'b0, lane_half};
      default: extended = load_access.word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      load_result.valid <= 1'b0;
    end else begin
      load_result.valid <= load_access.valid;
    end
    load_result.tag   <= load_access.dest;
    load_result.value <= extended;
  end

endmodule

//--- source/lsb_cache.sv
`timescale 1ns/1ps

module lsb_cache (
  input  logic                 clk,
  input  logic                 rst,
  input  lsb_pkg::head_req_t   head,
  input  lsb_pkg::line_t       wb_dat_r,
  input  logic                 wb_ack,
  output logic                 retire,
  output lsb_pkg::mem_access_t load_access,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output lsb_pkg::word_t       wb_adr,
  output lsb_pkg::line_t       wb_dat_w
);
  import lsb_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITEBACK,
    ST_FILL
  } cache_state_e;

  cache_tag_t   tag_q [CACHE_LINES];
  line_t        data_q [CACHE_LINES];
  logic         valid_q [CACHE_LINES];
  logic         dirty_q [CACHE_LINES];
  cache_state_e state;

  cache_tag_t   req_tag;
  cache_index_t req_index;
  line_offset_t req_offset;
  logic         hit;
  logic         is_store;
  word_t        lane_word;
  line_t        merged_line;
  word_t        fill_adr;
  word_t        victim_adr;

  assign {req_tag, req_index, req_offset} = head.addr;

  assign hit        = valid_q[req_index] && tag_q[req_index] == req_tag;
  assign is_store   = head.op inside {OP_SB, OP_SH, OP_SW};
  assign retire     = (state == ST_IDLE) && head.valid && hit;
  assign lane_word  = data_q[req_index][{req_offset[3:2], 5'b00000} +: 32];
  assign fill_adr   = {req_tag, req_index, {OFFSET_BITS{1'b0}}};
  // victim address rebuilt from the stored tag
  assign victim_adr = {tag_q[req_index], req_index, {OFFSET_BITS{1'b0}}};

  always_comb begin
    merged_line = data_q[req_index];
    case (head.op)
      OP_SB:   merged_line[{req_offset, 3'b000} +: 8]  = head.data[7:0];
      OP_SH:   merged_line[{req_offset, 3'b000} +: 16] = head.data[15:0];
      default: merged_line[{req_offset, 3'b000} +: 32] = head.data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      for (int i = 0; i < CACHE_LINES; i++) begin
        valid_q[i] <= 1'b0;
        dirty_q[i] <= 1'b0;
      end
    end else begin
      case (state)
        ST_IDLE: begin
          if (retire && is_store) begin
            data_q[req_index]  <= merged_line;
            dirty_q[req_index] <= 1'b1;
          end else if (head.valid && !hit) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            if (valid_q[req_index] && dirty_q[req_index]) begin
              wb_we    <= 1'b1;
              wb_adr   <= victim_adr;
              wb_dat_w <= data_q[req_index];
              state    <= ST_WRITEBACK;
            end else begin
              wb_we  <= 1'b0;
              wb_adr <= fill_adr;
              state  <= ST_FILL;
            end
          end
        end
        ST_WRITEBACK: begin
          if (wb_ack) begin
            wb_cyc             <= 1'b0;
            wb_stb             <= 1'b0;
            dirty_q[req_index] <= 1'b0;
            state              <= ST_FILL;
          end
        end
        ST_FILL: begin
          // bus idles one cycle after a write-back
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= 1'b0;
            wb_adr <= fill_adr;
          end else if (wb_ack) begin
            data_q[req_index]  <= wb_dat_r;
            tag_q[req_index]   <= req_tag;
            valid_q[req_index] <= 1'b1;
            dirty_q[req_index] <= 1'b0;
            wb_cyc             <= 1'b0;
            wb_stb             <= 1'b0;
            state              <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      load_access.valid <= 1'b0;
    end else begin
      load_access.valid <= retire && !is_store;
    end
    load_access.op     <= head.op;
    load_access.offset <= req_offset;
    load_access.word   <= lane_word;
    load_access.dest   <= head.dest;
  end

  // classic cycle, request held until the slave acks
  assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));

endmodule

//--- source/lsb_queue.sv
`timescale 1ns/1ps

module lsb_queue (
  input  logic               clk,
  input  logic               rst,
  input  lsb_pkg::issue_t    issue,
  input  lsb_pkg::cdb_t      cdb,
  input  lsb_pkg::rob_tag_t  commit_tag,
  input  logic               retire,
  output lsb_pkg::head_req_t head,
  output logic               full
);
  import lsb_pkg::*;

  logic     busy_q [LSB_DEPTH];
  mem_op_e  op_q [LSB_DEPTH];
  rob_tag_t dest_q [LSB_DEPTH];
  rob_tag_t qj_q [LSB_DEPTH];
  rob_tag_t qk_q [LSB_DEPTH];
  word_t    vj_q [LSB_DEPTH];
  word_t    vk_q [LSB_DEPTH];
  word_t    imm_q [LSB_DEPTH];
  logic     addr_pending_q [LSB_DEPTH];
  logic     committed_q [LSB_DEPTH];

  lsb_idx_t head_ptr;
  lsb_idx_t tail_ptr;
  logic [$clog2(LSB_DEPTH):0] count;

  lsb_idx_t calc_idx;
  logic     calc_found;
  logic     head_is_store;
  rob_tag_t issue_qj;
  rob_tag_t issue_qk;
  word_t    issue_vj;
  word_t    issue_vk;

  assign full = (count == LSB_DEPTH);

  // lowest slot with a known base and no address yet
  always_comb begin
    calc_found = 1'b0;
    calc_idx   = '0;
    for (int i = LSB_DEPTH - 1; i >= 0; i--) begin
      if (busy_q[i] && qj_q[i] == '0 && addr_pending_q[i]) begin
        calc_found = 1'b1;
        calc_idx   = lsb_idx_t'(i);
      end
    end
  end

  // operand arriving on the cdb in the issue cycle
  always_comb begin
    issue_qj = issue.qj;
    issue_vj = issue.vj;
    issue_qk = issue.qk;
    issue_vk = issue.vk;
    if (cdb.valid && issue.qj != '0 && issue.qj == cdb.tag) begin
      issue_qj = '0;
      issue_vj = cdb.value;
    end
    if (cdb.valid && issue.qk != '0 && issue.qk == cdb.tag) begin
      issue_qk = '0;
      issue_vk = cdb.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
      for (int i = 0; i < LSB_DEPTH; i++) begin
        busy_q[i] <= 1'b0;
      end
    end else begin
      if (issue.valid) begin
        busy_q[tail_ptr] <= 1'b1;
        tail_ptr         <= tail_ptr + 1'b1;
      end
      if (retire) begin
        busy_q[head_ptr] <= 1'b0;
        head_ptr         <= head_ptr + 1'b1;
      end
      case ({issue.valid, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < LSB_DEPTH; i++) begin
      if (cdb.valid && qj_q[i] != '0 && qj_q[i] == cdb.tag) begin
        qj_q[i] <= '0;
        vj_q[i] <= cdb.value;
      end
      if (cdb.valid && qk_q[i] != '0 && qk_q[i] == cdb.tag) begin
        qk_q[i] <= '0;
        vk_q[i] <= cdb.value;
      end
      if (commit_tag != '0 && busy_q[i] && dest_q[i] == commit_tag) begin
        committed_q[i] <= 1'b1;
      end
    end
    // vj turns from base into effective address
    if (calc_found) begin
      vj_q[calc_idx]           <= vj_q[calc_idx] + imm_q[calc_idx];
      addr_pending_q[calc_idx] <= 1'b0;
    end
    if (issue.valid) begin
      op_q[tail_ptr]           <= issue.op;
      dest_q[tail_ptr]         <= issue.dest;
      qj_q[tail_ptr]           <= issue_qj;
      vj_q[tail_ptr]           <= issue_vj;
      qk_q[tail_ptr]           <= issue_qk;
      vk_q[tail_ptr]           <= issue_vk;
      imm_q[tail_ptr]          <= issue.imm;
      addr_pending_q[tail_ptr] <= 1'b1;
      committed_q[tail_ptr]    <= (commit_tag != '0 && commit_tag == issue.dest);
    end
  end

  always_comb begin
    head_is_store = op_q[head_ptr] inside {OP_SB, OP_SH, OP_SW};
    head.valid    = busy_q[head_ptr] && qj_q[head_ptr] == '0 && qk_q[head_ptr] == '0 &&
                    !addr_pending_q[head_ptr] && (!head_is_store || committed_q[head_ptr]);
    head.op       = op_q[head_ptr];
    head.addr     = vj_q[head_ptr];
    head.data     = vk_q[head_ptr];
    head.dest     = dest_q[head_ptr];
  end

  // issue stage has to respect full
  assert property (@(posedge clk) disable iff (rst) issue.valid |-> !full);

  assert property (@(posedge clk) disable iff (rst) retire |-> head.valid);

endmodule

//--- source/lsb_pkg.sv
package lsb_pkg;

  // queue and cache geometry
  localparam int LSB_DEPTH   = 8;
  localparam int CACHE_LINES = 8;
  localparam int LINE_BYTES  = 16;
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = 3;

  typedef logic [31:0]                 word_t;
  typedef logic [3:0]                  rob_tag_t;
  typedef logic [$clog2(LSB_DEPTH)-1:0] lsb_idx_t;
  typedef logic [LINE_BYTES*8-1:0]     line_t;
  typedef logic [31-INDEX_BITS-OFFSET_BITS:0] cache_tag_t;
  typedef logic [INDEX_BITS-1:0]       cache_index_t;
  typedef logic [OFFSET_BITS-1:0]      line_offset_t;

  // loads first, stores after
  typedef enum logic [3:0] {
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
  } mem_op_e;

  // from the issue stage, qj/qk zero when the value is already in vj/vk
  typedef struct packed {
    logic     valid;
    mem_op_e  op;
    rob_tag_t dest;
    rob_tag_t qj;
    rob_tag_t qk;
    word_t    vj;
    word_t    vk;
    word_t    imm;
  } issue_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    word_t    value;
  } cdb_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    word_t    value;
  } load_result_t;

  // oldest queue entry, ready to go to the cache
  typedef struct packed {
    logic     valid;
    mem_op_e  op;
    word_t    addr;
    word_t    data;
    rob_tag_t dest;
  } head_req_t;

  // load hit, aligned lane word still to be extended
  typedef struct packed {
    logic         valid;
    mem_op_e      op;
    line_offset_t offset;
    word_t        word;
    rob_tag_t     dest;
  } mem_access_t;

endpackage
